// File: hw/periph_pkg.sv
// peripheral bus package with address map, sizes, uart timing, bus types and fsm states
package periph_pkg;

    // decimal byte address map
    localparam logic [31:0] ram_limit      = 32'd8000; // first non-ram byte
    localparam logic [31:0] uart_base      = 32'd8100; // uart window start
    localparam logic [31:0] uart_data_addr = 32'd8140; // write starts a frame
    localparam logic [31:0] uart_busy_addr = 32'd8144; // read returns busy

    // ram geometry
    localparam int ram_words  = 2048;               // 8192 bytes
    localparam int ram_addr_w = $clog2(ram_words);  // word index width

    // bus widths
    localparam int data_w = 32; // data bus
    localparam int mask_w = 4;  // one bit per byte lane

    // uart frame and timing
    localparam int uart_data_bits       = 8;  // lsb first
    localparam int uart_samples_per_bit = 16; // ticks per bit
    localparam int uart_clks_per_sample = 4;  // so 64 clocks per bit

    // master to target request
    typedef struct packed {
        logic [31:0]       addr;    // byte address
        logic [data_w-1:0] wdata;   // write payload
        logic              wr_en;   // 1 write, 0 read
        logic [mask_w-1:0] wr_mask; // byte enables
        logic              stb;     // one-cycle request strobe
    } bus_req_t;

    // target to master response
    typedef struct packed {
        logic [data_w-1:0] rdata; // valid with ack on reads
        logic              ack;   // one cycle after stb
    } bus_rsp_t;

    // decoded target of a request
    typedef enum logic [1:0] {
        ram,
        uart,
        none  // 8000..8099, answered by decoder
    } bus_target_t;

    // uart transmitter frame states
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } uart_state_t;

endpackage

// File: hw/data_ram.sv
// data ram with byte write mask, registered read and one-cycle ack
module data_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,  // already steered by decoder
    output periph_pkg::bus_rsp_t o_rsp
);

    logic [periph_pkg::data_w-1:0]     mem [periph_pkg::ram_words]; // word storage
    logic [periph_pkg::ram_addr_w-1:0] word_idx;                    // byte addr / 4
    logic [periph_pkg::data_w-1:0]     rdata_q;                     // read register
    logic                              ack_q;
    logic                              wr_stb;

    assign word_idx = i_req.addr[periph_pkg::ram_addr_w+1:2]; // drop byte offset
    assign wr_stb   = i_req.stb & i_req.wr_en;

    // byte lane writes, land on the edge closing the stb cycle
    always_ff @(posedge clk) begin
        if (wr_stb) begin
            for (int b = 0; b < periph_pkg::mask_w; b++) begin
                if (i_req.wr_mask[b]) begin
                    mem[word_idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8]; // masked lane only
                end
            end
        end
    end

    // registered read for block ram inference
    always_ff @(posedge clk) begin
        if (i_req.stb) begin
            rdata_q <= mem[word_idx]; // old word on same-cycle write
        end
    end

    // ack follows stb by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_req.stb; // reads and writes alike
        end
    end

    assign o_rsp.rdata = rdata_q;
    assign o_rsp.ack   = ack_q;

endmodule

// File: hw/uart_tx.sv
// uart transmitter, 16 samples per bit, 8n1, with data and busy registers on the bus
module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,  // uart window only
    output periph_pkg::bus_rsp_t o_rsp,
    output logic                 o_tx    // serial line, idles high
);

    periph_pkg::uart_state_t state_q;
    periph_pkg::uart_state_t state_d;

    logic [$clog2(periph_pkg::uart_clks_per_sample)-1:0] div_q;  // sample divider
    logic [$clog2(periph_pkg::uart_samples_per_bit)-1:0] smp_q;  // ticks within bit
    logic [$clog2(periph_pkg::uart_samples_per_bit)-1:0] smp_d;
    logic [$clog2(periph_pkg::uart_data_bits)-1:0]       bit_q;  // data bit index
    logic [$clog2(periph_pkg::uart_data_bits)-1:0]       bit_d;
    logic [periph_pkg::uart_data_bits-1:0]               shift_q; // lsb goes out first
    logic [periph_pkg::uart_data_bits-1:0]               shift_d;

    logic                          tick;       // one clock every 4
    logic                          smp_last;   // 16th tick of a bit
    logic                          busy;
    logic                          start_req;  // accepted data write
    logic                          busy_rd;    // read of busy register
    logic [periph_pkg::data_w-1:0] rdata_q;
    logic                          ack_q;

    assign tick      = (int'(div_q) == periph_pkg::uart_clks_per_sample - 1);
    assign smp_last  = (int'(smp_q) == periph_pkg::uart_samples_per_bit - 1);
    assign busy      = (state_q != periph_pkg::idle);
    assign start_req = i_req.stb && i_req.wr_en && (i_req.addr == periph_pkg::uart_data_addr);
    assign busy_rd   = i_req.stb && !i_req.wr_en && (i_req.addr == periph_pkg::uart_busy_addr);

    // free-running, not aligned to frame start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
        end else if (tick) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // frame fsm next state
    always_comb begin
        state_d = state_q;
        smp_d   = smp_q;
        bit_d   = bit_q;
        shift_d = shift_q;
        case (state_q)
            periph_pkg::idle: begin
                if (start_req) begin  // writes while busy fall through, ignored
                    shift_d = i_req.wdata[periph_pkg::uart_data_bits-1:0]; // low byte
                    smp_d   = '0;
                    state_d = periph_pkg::start;
                end
            end
            periph_pkg::start: begin
                if (tick) begin
                    if (smp_last) begin
                        smp_d   = '0;
                        bit_d   = '0;
                        state_d = periph_pkg::data;
                    end else begin
                        smp_d = smp_q + 1'b1;
                    end
                end
            end
            periph_pkg::data: begin
                if (tick) begin
                    if (smp_last) begin
                        smp_d   = '0;
                        shift_d = shift_q >> 1; // next bit to lsb
                        if (int'(bit_q) == periph_pkg::uart_data_bits - 1) begin
                            state_d = periph_pkg::stop;
                        end else begin
                            bit_d = bit_q + 1'b1;
                        end
                    end else begin
                        smp_d = smp_q + 1'b1;
                    end
                end
            end
            periph_pkg::stop: begin
                if (tick) begin
                    if (smp_last) begin
                        smp_d   = '0;
                        state_d = periph_pkg::idle; // busy drops here
                    end else begin
                        smp_d = smp_q + 1'b1;
                    end
                end
            end
            default: state_d = periph_pkg::idle;
        endcase
    end

    // fsm control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= periph_pkg::idle;
            smp_q   <= '0;
            bit_q   <= '0;
        end else begin
            state_q <= state_d;
            smp_q   <= smp_d;
            bit_q   <= bit_d;
        end
    end

    always_ff @(posedge clk) begin
        shift_q <= shift_d; // frame byte
    end

    // line level straight from state, low in the same cycle start is entered
    always_comb begin
        case (state_q)
            periph_pkg::start: o_tx = 1'b0;
            periph_pkg::data:  o_tx = shift_q[0];
            default:           o_tx = 1'b1; // idle and stop
        endcase
    end

    // register read path, everything but busy reads as zero
    always_ff @(posedge clk) begin
        if (i_req.stb) begin
            rdata_q <= busy_rd ? {{(periph_pkg::data_w-1){1'b0}}, busy} : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_req.stb; // every strobe acked
        end
    end

    assign o_rsp.rdata = rdata_q;
    assign o_rsp.ack   = ack_q;

endmodule

// File: hw/bus_decoder.sv
// address decoder steering requests to ram or uart and merging their responses
module bus_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,       // from master
    output periph_pkg::bus_req_t o_ram_req,
    input  periph_pkg::bus_rsp_t i_ram_rsp,
    output periph_pkg::bus_req_t o_uart_req,
    input  periph_pkg::bus_rsp_t i_uart_rsp,
    output periph_pkg::bus_rsp_t o_rsp        // to master
);

    periph_pkg::bus_target_t cur_target;    // decode of this cycle's addr
    periph_pkg::bus_target_t sel_target_q;  // target of request in flight
    logic                    none_ack_q;    // ack for the former i2c window

    // address compare, decimal boundaries
    always_comb begin
        if (i_req.addr < periph_pkg::ram_limit) begin
            cur_target = periph_pkg::ram;
        end else if (i_req.addr >= periph_pkg::uart_base) begin
            cur_target = periph_pkg::uart;
        end else begin
            cur_target = periph_pkg::none; // 8000..8099
        end
    end

    // steer full request, other target sees all zero
    assign o_ram_req  = (cur_target == periph_pkg::ram)  ? i_req : '0;
    assign o_uart_req = (cur_target == periph_pkg::uart) ? i_req : '0;

    // remember who owes the ack next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_target_q <= periph_pkg::none;
            none_ack_q   <= 1'b0;
        end else begin
            sel_target_q <= i_req.stb ? cur_target : periph_pkg::none; // idle parks on none
            none_ack_q   <= i_req.stb && (cur_target == periph_pkg::none);
        end
    end

    // response merge
    always_comb begin
        case (sel_target_q)
            periph_pkg::ram:  o_rsp = i_ram_rsp;
            periph_pkg::uart: o_rsp = i_uart_rsp;
            default: begin
                o_rsp.rdata = '0;          // unmapped reads as zero
                o_rsp.ack   = none_ack_q;
            end
        endcase
    end

endmodule

// File: hw/periph_top.sv
// data bus subsystem top joining decoder, data ram and uart transmitter
module periph_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,     // master request
    output periph_pkg::bus_rsp_t o_rsp,     // merged response
    output logic                 o_uart_tx  // serial out
);

    periph_pkg::bus_req_t ram_req;   // decoder to ram
    periph_pkg::bus_rsp_t ram_rsp;
    periph_pkg::bus_req_t uart_req;  // decoder to uart
    periph_pkg::bus_rsp_t uart_rsp;

    // address decode and response merge
    bus_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (i_req),
        .o_ram_req  (ram_req),
        .i_ram_rsp  (ram_rsp),
        .o_uart_req (uart_req),
        .i_uart_rsp (uart_rsp),
        .o_rsp      (o_rsp)
    );

    // below 8000
    data_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .i_req (ram_req),
        .o_rsp (ram_rsp)
    );

    // 8100 and up
    uart_tx u_uart (
        .clk   (clk),
        .rst_n (rst_n),
        .i_req (uart_req),
        .o_rsp (uart_rsp),
        .o_tx  (o_uart_tx)
    );

endmodule

// File: verification/periph_props.sv
// bus handshake and uart line assertions for the data bus subsystem top
module periph_props (
    input logic                    clk,
    input logic                    rst_n,
    input periph_pkg::bus_req_t    i_req,
    input periph_pkg::bus_rsp_t    o_rsp,
    input logic                    o_uart_tx,
    input periph_pkg::uart_state_t uart_state  // from the uart fsm
);

    logic none_hit; // addr inside the former i2c window

    assign none_hit = (i_req.addr >= periph_pkg::ram_limit) &&
                      (i_req.addr <  periph_pkg::uart_base);

    // every strobe answered exactly one cycle later, never otherwise
    ack_follows_stb: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_rsp.ack == $past(i_req.stb)
    ) else $error("ack is not a one-cycle copy of stb");

    // unmapped window answers with zero data
    none_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_req.stb && none_hit) |=> (o_rsp.ack && (o_rsp.rdata == '0))
    ) else $error("unmapped window ack missing or rdata not zero");

    // line rests high between frames
    tx_high_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (uart_state == periph_pkg::idle) |-> o_uart_tx
    ) else $error("uart line low while transmitter idle");

endmodule

bind periph_top periph_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_req      (i_req),
    .o_rsp      (o_rsp),
    .o_uart_tx  (o_uart_tx),
    .uart_state (u_uart.state_q)
);

// File: verification/periph_tb.sv
// testbench for the data bus subsystem with a master model, ram shadow and uart line monitor
module periph_tb;

    localparam int bit_clks   = periph_pkg::uart_samples_per_bit *
                                periph_pkg::uart_clks_per_sample; // 64 clocks per bit
    localparam int frame_clks = 10 * bit_clks;  // start, 8 data, stop
    localparam int ack_wait   = 8;              // cycles before ack counts as lost
    localparam int idle_polls = 600;            // busy polls of one clock each

    typedef struct {
        string       name;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        logic        wr;
        logic [31:0] exp;   // checked on reads only
    } vec_t;

    logic                 clk;
    logic                 rst_n;
    periph_pkg::bus_req_t req;
    periph_pkg::bus_rsp_t rsp;
    logic                 uart_tx;

    logic [31:0] shadow [periph_pkg::ram_words]; // expected ram contents
    vec_t        vecs [$];
    logic [31:0] rng = 32'h1abe;
    logic [7:0]  uart_bytes [3] = '{8'ha5, 8'h3c, 8'h81};
    logic [31:0] rdata;
    int          errors   = 0;
    int          err_mark = 0;  // errors at start of current test
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    periph_top periph_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_req     (req),
        .o_rsp     (rsp),
        .o_uart_tx (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == err_mark) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s", name);
        end
        err_mark = errors;
    endtask

    // new words only land in the byte lanes the mask selects
    task automatic add_write(input string tag, input logic [31:0] addr, input logic [3:0] mask);
        vec_t v;
        v.name  = $sformatf("%s_wr_%0d", tag, addr);
        v.addr  = addr;
        v.wdata = next_rand();
        v.mask  = mask;
        v.wr    = 1'b1;
        v.exp   = '0;
        if (addr < periph_pkg::ram_limit) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    shadow[addr[periph_pkg::ram_addr_w+1:2]][b*8 +: 8] = v.wdata[b*8 +: 8];
                end
            end
        end
        vecs.push_back(v);
    endtask

    task automatic add_read(input string tag, input logic [31:0] addr);
        vec_t v;
        v.name  = $sformatf("%s_rd_%0d", tag, addr);
        v.addr  = addr;
        v.wdata = '0;
        v.mask  = '0;
        v.wr    = 1'b0;
        if (addr < periph_pkg::ram_limit) begin
            v.exp = shadow[addr[periph_pkg::ram_addr_w+1:2]];
        end else begin
            v.exp = '0; // unmapped window or idle busy register
        end
        vecs.push_back(v);
    endtask

    task automatic build_table();
        logic [31:0] ram_addrs [5];
        ram_addrs = '{32'd0, 32'd4, 32'd1024, 32'd4000, 32'd7996};
        add_read("busy_reset", periph_pkg::uart_busy_addr);
        foreach (ram_addrs[k]) add_write("word", ram_addrs[k], 4'hf);
        foreach (ram_addrs[k]) add_read("word", ram_addrs[k]);
        add_write("mask", 32'd1024, 4'b0101);
        add_read("mask", 32'd1024);
        add_write("mask", 32'd7996, 4'b1000);
        add_read("mask", 32'd7996);
        add_write("mask", 32'd4, 4'b0010);
        add_read("mask", 32'd4);
        add_read("unmapped", 32'd8040);
        add_write("unmapped", 32'd8040, 4'hf);   // must not reach the ram
        add_read("unmapped", 32'd8040);
        foreach (ram_addrs[k]) add_read("intact", ram_addrs[k]);
    endtask

    // one request entered and left on a falling edge
    task automatic bus_xfer(input string name, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] mask, input logic wr, output logic [31:0] data);
        int waited;
        req.addr    = addr;
        req.wdata   = wdata;
        req.wr_mask = mask;
        req.wr_en   = wr;
        req.stb     = 1'b1;
        @(negedge clk);
        req    = '0;  // single-cycle strobe
        waited = 0;
        while (rsp.ack !== 1'b1 && waited < ack_wait) begin
            @(negedge clk);
            waited++;
        end
        if (rsp.ack !== 1'b1) begin
            $display("ERROR: %s got no ack within %0d cycles", name, ack_wait);
            errors++;
        end
        data = rsp.rdata;
    endtask

    task automatic wait_uart_idle(input string name);
        logic [31:0] busy;
        int          polls;
        busy  = 32'd1;
        polls = 0;
        while (busy !== 32'd0 && polls < idle_polls) begin
            bus_xfer(name, periph_pkg::uart_busy_addr, '0, 4'h0, 1'b0, busy);
            polls++;
        end
        if (busy !== 32'd0) begin
            $display("ERROR: %s uart still busy after %0d polls", name, polls);
            errors++;
        end
    endtask

    // line monitor sampling mid-bit from the start edge
    task automatic uart_receive(input string name, input int max_wait,
                                output logic [7:0] data, output bit seen);
        int waited;
        waited = 0;
        data   = '0;
        seen   = 1'b0;
        while (uart_tx !== 1'b0 && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx === 1'b0) begin
            seen = 1'b1;
            repeat (bit_clks + bit_clks / 2) @(negedge clk); // centre of bit 0
            for (int i = 0; i < 8; i++) begin
                data[i] = uart_tx;  // lsb first
                repeat (bit_clks) @(negedge clk);
            end
            compare({name, "_stop"}, 32'd1, 32'(uart_tx));
        end
    endtask

    task automatic back_to_back_test(input string name);
        logic [31:0] addrs [5];
        logic [31:0] got [$];
        addrs = '{32'd7996, 32'd0, 32'd4000, 32'd4, 32'd1024};
        for (int k = 0; k < 5; k++) begin
            req      = '0;
            req.addr = addrs[k];
            req.stb  = 1'b1;
            @(negedge clk);
            if (rsp.ack) begin
                got.push_back(rsp.rdata); // ack of request k arrives with request k+1
            end
        end
        req = '0;
        compare({name, "_acks"}, 32'd5, 32'(got.size()));
        for (int k = 0; k < got.size(); k++) begin
            compare(name, shadow[addrs[k][periph_pkg::ram_addr_w+1:2]], got[k]);
        end
    endtask

    task automatic uart_frame_test(input string name, input logic [7:0] tx_byte);
        logic [7:0]  rx_byte;
        logic [31:0] rnd;
        logic [31:0] busy;
        bit          seen;
        rnd = next_rand();
        fork
            uart_receive(name, 4 * ack_wait, rx_byte, seen);
            begin
                bus_xfer(name, periph_pkg::uart_data_addr, {rnd[31:8], tx_byte}, 4'hf, 1'b1, busy);
                bus_xfer(name, periph_pkg::uart_busy_addr, '0, 4'h0, 1'b0, busy);
                compare({name, "_busy"}, 32'd1, busy);
            end
        join
        if (!seen) begin
            $display("ERROR: %s no start bit on the uart line", name);
            errors++;
        end
        compare(name, 32'(tx_byte), 32'(rx_byte));
        wait_uart_idle(name);
    endtask

    // second write lands while busy and is dropped
    task automatic uart_overrun_test(input string name, input logic [7:0] first,
                                     input logic [7:0] second);
        logic [7:0]  rx_byte;
        logic [31:0] dummy;
        bit          seen;
        fork
            uart_receive(name, 4 * ack_wait, rx_byte, seen);
            begin
                bus_xfer(name, periph_pkg::uart_data_addr, {24'h0, first}, 4'hf, 1'b1, dummy);
                bus_xfer(name, periph_pkg::uart_data_addr, {24'h0, second}, 4'hf, 1'b1, dummy);
            end
        join
        if (!seen) begin
            $display("ERROR: %s no start bit on the uart line", name);
            errors++;
        end
        compare(name, 32'(first), 32'(rx_byte));
        wait_uart_idle(name);
        uart_receive(name, 2 * frame_clks, rx_byte, seen);
        compare({name, "_no_frame"}, 32'd0, 32'(seen));
    endtask

    initial begin
        req   = '0;
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        build_table();
        foreach (vecs[i]) begin
            bus_xfer(vecs[i].name, vecs[i].addr, vecs[i].wdata, vecs[i].mask, vecs[i].wr, rdata);
            if (!vecs[i].wr) begin
                compare(vecs[i].name, vecs[i].exp, rdata);
            end
            report_test(vecs[i].name);
        end
        back_to_back_test("b2b_reads");
        report_test("b2b_reads");
        foreach (uart_bytes[i]) begin
            uart_frame_test($sformatf("uart_frame_%0d", i), uart_bytes[i]);
            report_test($sformatf("uart_frame_%0d", i));
        end
        uart_overrun_test("uart_write_while_busy", 8'h5a, 8'hc3);
        report_test("uart_write_while_busy");
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
hw/periph_pkg.sv
hw/data_ram.sv
hw/uart_tx.sv
hw/bus_decoder.sv
hw/periph_top.sv
verification/periph_props.sv
verification/periph_tb.sv

// File: Makefile
TOP := periph_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

obj_dir/V$(TOP): all.f $(wildcard hw/*.sv verification/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)
